//--- rom_bus_if.sv
// ==============================
// Internal buses toward the SDRAM arbiter
// rom_bus_if carries slot reads, prog_bus_if loader writes
// ==============================
`timescale 1ns/1ps

interface rom_bus_if;
    import sbaskt_pkg::*;

    logic                req;
    logic [SDRAM_AW-1:0] addr;    // Word address, held until ack
    logic                ack;
    logic [SDRAM_DW-1:0] data;
    logic                data_rdy;

    modport slot (output req, addr, input ack, data, data_rdy);
    modport arb  (input req, addr, output ack, data, data_rdy);
endinterface

interface prog_bus_if;
    import sbaskt_pkg::*;

    logic                we;
    logic [SDRAM_AW-1:0] addr;
    logic [SDRAM_DW-1:0] data;
    logic [1:0]          mask;    // Active low byte enables
    logic                ack;

    modport loader (output we, addr, data, mask, input ack);
    modport arb    (input we, addr, data, mask, output ack);
endinterface

//--- rom_loader.sv
// ==============================
// Download byte stream to SDRAM word writes
// Reorders graphics regions on the way in
// Bytes from PROM_START on go to the PROM strobe
// ==============================
`timescale 1ns/1ps

module rom_loader(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         downloading,
    input  logic [sbaskt_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                   ioctl_dout,
    input  logic                         ioctl_wr,
    output logic                         prom_we,
    output logic [sbaskt_pkg::PROM_AW-1:0] prom_addr,
    output logic [7:0]                   prom_data,
    prog_bus_if.loader                   prog
);
    import sbaskt_pkg::*;

    logic [21:0]         byte_addr;
    logic [21:0]         perm_addr;
    logic [7:0]          byte_data;
    logic [IOCTL_AW-1:0] prom_off;
    logic                in_scr;
    logic                in_obj;
    logic                is_prom;
    logic                take;

    assign take     = downloading && ioctl_wr;
    assign is_prom  = ioctl_addr >= PROM_START;
    assign prom_off = ioctl_addr - PROM_START;

    always_comb begin
        byte_addr = ioctl_addr[21:0];
        in_scr    = byte_addr >= SCR_START && byte_addr < OBJ_START;
        in_obj    = byte_addr >= OBJ_START && byte_addr < PCM_START;
        perm_addr = byte_addr;
        byte_data = ioctl_dout;
        if (in_scr) begin
            byte_data = {ioctl_dout[3:0], ioctl_dout[7:4]};   // Nibble swap
        end
        if (in_obj) begin
            perm_addr[5:0] = {byte_addr[5], byte_addr[2:0], ~byte_addr[4], ~byte_addr[3]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prog.we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;                // Single cycle strobe
            if (prog.ack) prog.we <= 1'b0;
            if (take) begin
                if (is_prom) prom_we <= 1'b1;
                else prog.we <= 1'b1;
            end
        end
    end

    // Payload held stable until the arbiter acks
    always_ff @(posedge clk) begin
        if (take) begin
            prog.addr <= {1'b0, perm_addr[21:1]};
            prog.data <= {byte_data, byte_data};
            prog.mask <= perm_addr[0] ? 2'b01 : 2'b10;  // Even bytes use the low half
            prom_addr <= prom_off[PROM_AW-1:0];
            prom_data <= ioctl_dout;
        end
    end

    // Host must wait for the SDRAM write to finish
    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        take |-> !prog.we);

endmodule

//--- rom_slot.sv
// ==============================
// One-entry caching ROM slot
// Client cs/addr in, SDRAM word reads out
// DW 32 fetches two words, DW 8 one
// ==============================
`timescale 1ns/1ps

module rom_slot #(
    parameter int AW = 16,
    parameter int DW = 8,
    parameter logic [sbaskt_pkg::SDRAM_AW-1:0] OFFSET = '0
)(
    input  logic          clk,
    input  logic          reset,
    input  logic          downloading,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output logic [DW-1:0] data,
    output logic          ok,
    rom_bus_if.slot       bus
);
    import sbaskt_pkg::*;

    logic [AW-1:0] base_addr;
    logic [AW-1:0] cache_addr;
    logic [AW-1:0] fetch_addr;
    logic [31:0]   cache_data;
    logic          valid;
    logic          busy;
    logic          half;      // High word of a 32-bit item in flight
    logic          hit;
    logic          start_fetch;
    logic          next_half;
    logic          last_word;

    // 32-bit items sit on 4-byte boundaries and bytes are cached per word
    assign base_addr   = DW == 32 ? {addr[AW-1:2], 2'b00} : {addr[AW-1:1], 1'b0};
    assign hit         = valid && cache_addr == base_addr;
    assign start_fetch = cs && !hit && !busy && !downloading;
    assign next_half   = busy && bus.data_rdy && DW == 32 && !half;
    assign last_word   = busy && bus.data_rdy && !next_half;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.req <= 1'b0;
            busy    <= 1'b0;
            half    <= 1'b0;
            valid   <= 1'b0;
            ok      <= 1'b0;
        end else begin
            ok <= cs && hit;
            if (bus.ack) bus.req <= 1'b0;
            if (start_fetch) begin
                bus.req <= 1'b1;
                busy    <= 1'b1;
                half    <= 1'b0;
                valid   <= 1'b0;     // Cache is overwritten from now on
            end
            if (next_half) begin
                bus.req <= 1'b1;
                half    <= 1'b1;
            end
            if (last_word) begin
                busy  <= 1'b0;
                valid <= !downloading;
            end
            if (downloading) valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_fetch) begin
            fetch_addr <= base_addr;
            bus.addr   <= OFFSET + SDRAM_AW'(base_addr[AW-1:1]);
        end
        if (next_half) bus.addr <= bus.addr + 1'b1;
        if (busy && bus.data_rdy) begin
            if (half) cache_data[31:16] <= bus.data;
            else cache_data[15:0] <= bus.data;
        end
        if (last_word) cache_addr <= fetch_addr;
        data <= DW'(DW == 8 && addr[0] ? cache_data[15:8] : cache_data);  // Byte pick
    end

    // Request is held until the arbiter takes it
    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        bus.req && !bus.ack |=> bus.req);

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module sbaskt_tb -o sbaskt_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sbaskt_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

//--- sbaskt_pkg.sv
// ==============================
// Shared constants for the ROM subsystem
// Region offsets, bus widths, slot sizes and arbiter encodings
// Modules import it inside their body
// ==============================
package sbaskt_pkg;

    localparam int SDRAM_AW = 22;     // SDRAM word address
    localparam int SDRAM_DW = 16;
    localparam int IOCTL_AW = 25;     // Host download byte address
    localparam int PROM_AW  = 11;

    // Client byte-address widths
    localparam int SCR_AW  = 14;
    localparam int OBJ_AW  = 15;
    localparam int MAIN_AW = 16;

    // Byte offsets in SDRAM with main code below SCR_START
    localparam logic [21:0] SCR_START = 22'h01_0000;
    localparam logic [21:0] OBJ_START = 22'h01_4000;
    localparam logic [21:0] PCM_START = 22'h01_C000;
    localparam logic [IOCTL_AW-1:0] PROM_START = 25'h002_4000;

    // Arbiter FSM states
    localparam logic [1:0] ARB_IDLE = 2'd0;
    localparam logic [1:0] ARB_REQ  = 2'd1;
    localparam logic [1:0] ARB_WAIT = 2'd2;

    // Arbiter owners, in priority order
    localparam logic [1:0] OWN_PROG = 2'd0;
    localparam logic [1:0] OWN_SCR  = 2'd1;
    localparam logic [1:0] OWN_OBJ  = 2'd2;
    localparam logic [1:0] OWN_MAIN = 2'd3;

endpackage

//--- sbaskt_rom_sys.sv
// ==============================
// ROM subsystem top level
// Host download, PROM strobe, SDRAM port and three ROM clients
// ==============================
`timescale 1ns/1ps

module sbaskt_rom_sys(
    input  logic                            clk,
    input  logic                            reset,
    // Host download
    input  logic                            downloading,
    input  logic [sbaskt_pkg::IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                      ioctl_dout,
    input  logic                            ioctl_wr,
    // Colour PROM
    output logic                            prom_we,
    output logic [sbaskt_pkg::PROM_AW-1:0]  prom_addr,
    output logic [7:0]                      prom_data,
    // SDRAM
    output logic                            sdram_req,
    output logic                            sdram_we,
    output logic [sbaskt_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic [sbaskt_pkg::SDRAM_DW-1:0] sdram_din,
    output logic [1:0]                      sdram_mask,
    input  logic                            sdram_ack,
    input  logic [sbaskt_pkg::SDRAM_DW-1:0] data_read,
    input  logic                            data_rdy,
    // Clients
    input  logic                            scr_cs,
    input  logic [sbaskt_pkg::SCR_AW-1:0]   scr_addr,
    output logic [31:0]                     scr_data,
    output logic                            scr_ok,
    input  logic                            obj_cs,
    input  logic [sbaskt_pkg::OBJ_AW-1:0]   obj_addr,
    output logic [31:0]                     obj_data,
    output logic                            obj_ok,
    input  logic                            main_cs,
    input  logic [sbaskt_pkg::MAIN_AW-1:0]  main_addr,
    output logic [7:0]                      main_data,
    output logic                            main_ok
);
    import sbaskt_pkg::*;

    prog_bus_if prog_bus();
    rom_bus_if  scr_bus();
    rom_bus_if  obj_bus();
    rom_bus_if  main_bus();

    rom_loader u_loader(
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prom_we     ( prom_we     ),
        .prom_addr   ( prom_addr   ),
        .prom_data   ( prom_data   ),
        .prog        ( prog_bus    )
    );

    rom_slot #(.AW(SCR_AW), .DW(32), .OFFSET(SCR_START >> 1)) u_scr(
        .clk(clk), .reset(reset), .downloading(downloading),
        .cs(scr_cs), .addr(scr_addr), .data(scr_data), .ok(scr_ok), .bus(scr_bus)
    );

    rom_slot #(.AW(OBJ_AW), .DW(32), .OFFSET(OBJ_START >> 1)) u_obj(
        .clk(clk), .reset(reset), .downloading(downloading),
        .cs(obj_cs), .addr(obj_addr), .data(obj_data), .ok(obj_ok), .bus(obj_bus)
    );

    // Main code starts at SDRAM address zero
    rom_slot #(.AW(MAIN_AW), .DW(8), .OFFSET('0)) u_main(
        .clk(clk), .reset(reset), .downloading(downloading),
        .cs(main_cs), .addr(main_addr), .data(main_data), .ok(main_ok), .bus(main_bus)
    );

    sdram_arbiter u_arb(
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .prog        ( prog_bus    ),
        .scr         ( scr_bus     ),
        .obj         ( obj_bus     ),
        .main        ( main_bus    ),
        .sdram_req   ( sdram_req   ),
        .sdram_we    ( sdram_we    ),
        .sdram_addr  ( sdram_addr  ),
        .sdram_din   ( sdram_din   ),
        .sdram_mask  ( sdram_mask  ),
        .sdram_ack   ( sdram_ack   ),
        .data_read   ( data_read   ),
        .data_rdy    ( data_rdy    )
    );

endmodule

//--- sbaskt_tb.sv
// ==============================
// Testbench for the ROM subsystem
// Downloads sample blocks of every region, then reads them back through the slots
// ==============================
`timescale 1ns/1ps

module sbaskt_tb;
    import sbaskt_pkg::*;

    localparam int          CLK_PERIOD = 100;
    localparam int unsigned MAIN_BLK   = 32'h0000_1200;
    localparam int unsigned SCR_OFF    = 32'h200;     // Client offsets inside the regions
    localparam int unsigned OBJ_OFF    = 32'h100;
    localparam int          BLK_LEN    = 256;
    localparam int          PROM_LEN   = 32;
    localparam int          WAIT_LIMIT = 32;
    localparam int          READ_LIMIT = 64;
    localparam int          NUM_BYTES  = 3 * BLK_LEN + PROM_LEN;
    localparam int          NUM_READS  = BLK_LEN + BLK_LEN / 2 + 3;
    localparam int          WATCHDOG_NS =
        (NUM_BYTES * WAIT_LIMIT + NUM_READS * READ_LIMIT + 100) * CLK_PERIOD;

    logic               clk = 1'b0;
    logic               reset, downloading, ioctl_wr;
    logic [24:0]        ioctl_addr;
    logic [7:0]         ioctl_dout;
    logic               prom_we;
    logic [10:0]        prom_addr;
    logic [7:0]         prom_data, main_data;
    logic               sdram_req, sdram_we, sdram_ack, data_rdy;
    logic [21:0]        sdram_addr;
    logic [15:0]        sdram_din, data_read;
    logic [1:0]         sdram_mask;
    logic               scr_cs, obj_cs, main_cs, scr_ok, obj_ok, main_ok;
    logic [SCR_AW-1:0]  scr_addr;
    logic [OBJ_AW-1:0]  obj_addr;
    logic [MAIN_AW-1:0] main_addr;
    logic [31:0]        scr_data, obj_data;
    logic [7:0]         exp_mem [int unsigned];    // Expected SDRAM content by byte
    logic               req_last = 1'b0;
    int                 errors = 0, timeouts = 0;
    int                 req_pulses = 0, writes_seen = 0, writes_due = 0;

    sbaskt_rom_sys sbaskt_rom_sys_i(.*);

    sdram_model u_sdram(
        .clk(clk), .reset(reset), .req(sdram_req), .we(sdram_we), .addr(sdram_addr),
        .din(sdram_din), .mask(sdram_mask), .ack(sdram_ack), .dout(data_read), .rdy(data_rdy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (sdram_req && !req_last) req_pulses++;
        if (sdram_req && sdram_ack && sdram_we) writes_seen++;
        req_last = sdram_req;
    end

    a_req_hold: assert property (@(posedge clk) disable iff (reset)
        sdram_req && !sdram_ack |=> $stable(sdram_addr) && $stable(sdram_we))
        else begin
            errors++;
            $display("error @%0t ns: SDRAM request changed before ack", $time);
        end

    // PROM strobe is one cycle and never reaches the SDRAM
    a_prom_pulse: assert property (@(posedge clk) disable iff (reset)
        prom_we |=> !prom_we && !sdram_req)
        else begin
            errors++;
            $display("error @%0t ns: PROM byte was not a lone strobe", $time);
        end

    function automatic logic [7:0] fill_byte(input int unsigned a);
        int unsigned h;
        h = (a * 32'd37) ^ (a >> 8) ^ (a >> 16) ^ 32'hA5;
        return h[7:0];
    endfunction

    function automatic int unsigned obj_perm(input int unsigned b);
        int unsigned p;
        p = b;
        p[5:0] = {b[5], b[2], b[1], b[0], ~b[4], ~b[3]};
        return p;
    endfunction

    // Slot 0 is scroll, 1 object and 2 main
    function automatic logic [31:0] expected_word(input int which, input int unsigned a);
        int unsigned base;
        base = which == 0 ? 32'(SCR_START) + a : 32'(OBJ_START) + a;
        if (which == 2) return {24'h0, exp_mem[a]};
        return {exp_mem[base + 3], exp_mem[base + 2], exp_mem[base + 1], exp_mem[base]};
    endfunction

    task automatic download_byte(input int unsigned a);
        logic [7:0] d;
        logic       is_prom;
        logic       done;
        int         n;
        d       = fill_byte(a);
        is_prom = a >= 32'(PROM_START);
        n       = 0;
        if (!is_prom) begin
            writes_due++;
            if (a >= 32'(OBJ_START) && a < 32'(PCM_START)) exp_mem[obj_perm(a)] = d;
            else if (a >= 32'(SCR_START) && a < 32'(OBJ_START)) exp_mem[a] = {d[3:0], d[7:4]};
            else exp_mem[a] = d;
        end
        @(posedge clk);
        ioctl_addr <= 25'(a);
        ioctl_dout <= d;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr   <= 1'b0;
        do begin
            @(negedge clk);
            n++;
            done = is_prom ? prom_we : (sdram_req && sdram_ack && sdram_we);
        end while (!done && n < WAIT_LIMIT);
        assert (done) else begin
            timeouts++;
            $display("download byte %h was never written out", a);
        end
        if (is_prom && done) begin
            assert (prom_addr == 11'(a - 32'(PROM_START)) && prom_data == d) else begin
                errors++;
                $display("error @%0t ns: PROM got %h=%h, expected %h=%h", $time,
                    prom_addr, prom_data, 11'(a - 32'(PROM_START)), d);
            end
        end
    endtask

    task automatic check_read(input int which, input int unsigned a, input logic hit);
        logic [31:0] got;
        logic        ok;
        int          n;
        int          pulses;
        @(posedge clk);
        pulses  = req_pulses;
        scr_cs  <= 1'b0;        // Drop cs first so a stale ok cannot pass
        obj_cs  <= 1'b0;
        main_cs <= 1'b0;
        @(posedge clk);
        case (which)
            0: begin
                scr_cs   <= 1'b1;
                scr_addr <= SCR_AW'(a);
            end
            1: begin
                obj_cs   <= 1'b1;
                obj_addr <= OBJ_AW'(a);
            end
            default: begin
                main_cs   <= 1'b1;
                main_addr <= MAIN_AW'(a);
            end
        endcase
        n = 0;
        do begin
            @(negedge clk);
            n++;
            ok  = which == 0 ? scr_ok : which == 1 ? obj_ok : main_ok;
            got = which == 0 ? scr_data : which == 1 ? obj_data : {24'h0, main_data};
        end while (!ok && n < READ_LIMIT);
        assert (ok) else begin
            timeouts++;
            $display("slot %0d never raised ok for address %h", which, a);
        end
        assert (!ok || got == expected_word(which, a)) else begin
            errors++;
            $display("error @%0t ns: slot %0d address %h read %h, expected %h", $time,
                which, a, got, expected_word(which, a));
        end
        if (hit) begin
            repeat (4) @(posedge clk);    // Long enough for a refetch to reach sdram_req
            assert (n == 2 && req_pulses == pulses) else begin
                errors++;
                $display("error @%0t ns: repeat read at %h took %0d cycles, %0d requests",
                    $time, a, n, req_pulses - pulses);
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        scr_cs      = 1'b0;
        obj_cs      = 1'b0;
        main_cs     = 1'b0;
        scr_addr    = '0;
        obj_addr    = '0;
        main_addr   = '0;
        repeat (10) @(posedge clk);
        reset       <= 1'b0;
        downloading <= 1'b1;
        @(negedge clk);
        assert (!sdram_req && !prom_we && !scr_ok && !obj_ok && !main_ok) else begin
            errors++;
            $display("error @%0t ns: outputs not idle after reset", $time);
        end
        for (int i = 0; i < BLK_LEN; i++) download_byte(MAIN_BLK + i);
        for (int i = 0; i < BLK_LEN; i++) download_byte(32'(SCR_START) + SCR_OFF + i);
        for (int i = 0; i < BLK_LEN; i++) download_byte(32'(OBJ_START) + OBJ_OFF + i);
        for (int i = 0; i < PROM_LEN; i++) download_byte(32'(PROM_START) + i);
        @(posedge clk);
        downloading <= 1'b0;
        for (int i = 0; i < BLK_LEN; i++) check_read(2, MAIN_BLK + i, 1'b0);
        for (int i = 0; i < BLK_LEN; i += 4) check_read(0, SCR_OFF + i, 1'b0);
        for (int i = BLK_LEN - 4; i >= 0; i -= 4) check_read(1, OBJ_OFF + i, 1'b0);
        check_read(2, MAIN_BLK + BLK_LEN - 1, 1'b1);    // Same addresses as the last reads
        check_read(0, SCR_OFF + BLK_LEN - 4, 1'b1);
        check_read(1, OBJ_OFF, 1'b1);
        @(posedge clk);
        assert (writes_seen == writes_due) else begin
            errors++;
            $display("error @%0t ns: %0d SDRAM writes, expected %0d", $time,
                writes_seen, writes_due);
        end
        $display("%0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) $display("Test OK");
        else $display("Test FAILED");
        $finish;
    end

endmodule

//--- sdram_arbiter.sv
// ==============================
// Owner of the single SDRAM port
// Loader writes first, then scroll, object and main reads
// Reads only once the download is over
// ==============================
`timescale 1ns/1ps

module sdram_arbiter(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            downloading,
    prog_bus_if.arb                         prog,
    rom_bus_if.arb                          scr,
    rom_bus_if.arb                          obj,
    rom_bus_if.arb                          main,
    output logic                            sdram_req,
    output logic                            sdram_we,
    output logic [sbaskt_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic [sbaskt_pkg::SDRAM_DW-1:0] sdram_din,
    output logic [1:0]                      sdram_mask,
    input  logic                            sdram_ack,
    input  logic [sbaskt_pkg::SDRAM_DW-1:0] data_read,
    input  logic                            data_rdy
);
    import sbaskt_pkg::*;

    logic [1:0]          state;
    logic [1:0]          owner;
    logic [1:0]          grant_own;
    logic                grant_en;
    logic [SDRAM_AW-1:0] grant_addr;
    logic                ack_phase;
    logic                data_phase;

    // Fixed priority pick
    always_comb begin
        grant_en   = 1'b0;
        grant_own  = OWN_PROG;
        grant_addr = prog.addr;
        if (prog.we) begin
            grant_en = 1'b1;
        end else if (!downloading) begin
            grant_en = 1'b1;
            if (scr.req) begin
                grant_own  = OWN_SCR;
                grant_addr = scr.addr;
            end else if (obj.req) begin
                grant_own  = OWN_OBJ;
                grant_addr = obj.addr;
            end else if (main.req) begin
                grant_own  = OWN_MAIN;
                grant_addr = main.addr;
            end else begin
                grant_en = 1'b0;
            end
        end
    end

    assign ack_phase  = state == ARB_REQ && sdram_ack;
    assign data_phase = state == ARB_WAIT && data_rdy;

    // Ack and data_rdy only reach the current owner
    assign prog.ack     = ack_phase && owner == OWN_PROG;
    assign scr.ack      = ack_phase && owner == OWN_SCR;
    assign obj.ack      = ack_phase && owner == OWN_OBJ;
    assign main.ack     = ack_phase && owner == OWN_MAIN;
    assign scr.data_rdy  = data_phase && owner == OWN_SCR;
    assign obj.data_rdy  = data_phase && owner == OWN_OBJ;
    assign main.data_rdy = data_phase && owner == OWN_MAIN;
    assign scr.data     = data_read;
    assign obj.data     = data_read;
    assign main.data    = data_read;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ARB_IDLE;
            owner     <= OWN_PROG;
            sdram_req <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: if (grant_en) begin
                    state     <= ARB_REQ;
                    owner     <= grant_own;
                    sdram_req <= 1'b1;
                end
                ARB_REQ: if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= owner == OWN_PROG ? ARB_IDLE : ARB_WAIT;  // Writes end on ack
                end
                ARB_WAIT: if (data_rdy) state <= ARB_IDLE;
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && grant_en) begin
            sdram_addr <= grant_addr;
            sdram_we   <= grant_own == OWN_PROG;
            sdram_din  <= prog.data;
            sdram_mask <= grant_own == OWN_PROG ? prog.mask : 2'b00;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        sdram_req && !sdram_ack |=> $stable(sdram_addr));

endmodule

//--- sdram_model.sv
// ==============================
// SDRAM stand-in for the testbench
// Random ack and data_rdy delays, masked word writes
// ==============================
`timescale 1ns/1ps

module sdram_model(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            req,
    input  logic                            we,
    input  logic [sbaskt_pkg::SDRAM_AW-1:0] addr,
    input  logic [15:0]                     din,
    input  logic [1:0]                      mask,
    output logic                            ack,
    output logic [15:0]                     dout,
    output logic                            rdy
);
    import sbaskt_pkg::*;

    logic [15:0]         mem [logic [SDRAM_AW-1:0]];
    logic [15:0]         word;
    logic [SDRAM_AW-1:0] rd_addr;
    logic                busy;       // Request seen, ack pending
    logic                reading;    // Acked read, data pending
    integer              seed = 44;
    integer              delay;

    always @(posedge clk) begin
        ack <= 1'b0;
        rdy <= 1'b0;
        if (reset) begin
            busy    <= 1'b0;
            reading <= 1'b0;
            delay   <= 0;
            dout    <= 16'h0000;
        end else if (delay > 0) begin
            delay <= delay - 1;     // Shared by the ack and data waits
        end else if (reading) begin
            rdy     <= 1'b1;
            dout    <= mem.exists(rd_addr) ? mem[rd_addr] : 16'h0000;
            reading <= 1'b0;
        end else if (busy) begin
            ack  <= 1'b1;
            busy <= 1'b0;
            if (we) begin
                word = mem.exists(addr) ? mem[addr] : 16'h0000;
                if (!mask[0]) word[7:0] = din[7:0];     // Mask is active low
                if (!mask[1]) word[15:8] = din[15:8];
                mem[addr] = word;
            end else begin
                reading <= 1'b1;
                rd_addr <= addr;
                delay   <= $unsigned($random(seed)) % 4;
            end
        end else if (req && !ack) begin
            busy  <= 1'b1;
            delay <= $unsigned($random(seed)) % 4;
        end
    end

endmodule

//--- tb.f
sbaskt_pkg.sv
rom_bus_if.sv
rom_loader.sv
rom_slot.sv
sdram_arbiter.sv
sbaskt_rom_sys.sv
sdram_model.sv
sbaskt_tb.sv
